//--- fetch_front_top.f
fetch_pkg.sv
inst_fetch.sv
stage_reg.sv
inst_decode.sv
fetch_front_top.sv
fetch_front_properties.sv
tb_fetch_front.sv

//--- tb_fetch_front.sv
`timescale 1ns/10ps

module tb_fetch_front;

    logic                       clk;
    logic                       rst_n_i;
    logic                       arvalid_o;
    logic                       arready_i;
    logic [31:0]                araddr_o;
    logic [2:0]                 arprot_o;
    logic                       rvalid_i;
    logic                       rready_o;
    logic [31:0]                rdata_i;
    logic [1:0]                 rresp_i;
    fetch_pkg::decoded_t        out_o;
    logic                       out_valid_o;
    logic                       out_ready_i;

    logic [31:0]         mem [0:63];
    fetch_pkg::decoded_t exp_q[$];
    fetch_pkg::decoded_t held;
    integer              seed = 32'hceae;
    integer              errs = 0;
    integer              checks = 0;
    integer              got = 0;
    integer              cycles = 0;
    logic                checking = 1'b0;
    logic                rand_ready = 1'b0;
    logic                hold_pending = 1'b0;
    logic [31:0]         raddr;
    logic                rpend;
    integer              ar_wait;
    integer              r_wait;

    fetch_front_top fetch_front_top_inst (.*);

    bind fetch_front_top fetch_front_properties u_props (
        .clk (clk), .rst_n_i (rst_n_i),
        .arvalid_i (arvalid_o), .arready_i (arready_i), .araddr_i (araddr_o),
        .rvalid_i (rvalid_i), .rready_i (rready_o),
        .out_i (out_o), .out_valid_i (out_valid_o), .out_ready_i (out_ready_i),
        .redirect_i (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==================================================
    // AXI4-Lite slave and consumer ready
    // ==================================================

    // Random waits of 0 to 3 cycles before arready and before rvalid
    always @(posedge clk) begin
        out_ready_i <= rand_ready ? ($random(seed) & 1) : 1'b1;
        if (!rst_n_i) begin
            arready_i <= 1'b0;
            rvalid_i  <= 1'b0;
            rpend     <= 1'b0;
            ar_wait   <= $random(seed) & 3;
        end else begin
            if (arvalid_o && arready_i) begin
                arready_i <= 1'b0;
                raddr     <= araddr_o;
                rpend     <= 1'b1;
                r_wait    <= $random(seed) & 3;
                ar_wait   <= $random(seed) & 3;
            end else if (arvalid_o && !arready_i) begin
                if (ar_wait == 0) arready_i <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end
            if (rvalid_i && rready_o) begin
                rvalid_i <= 1'b0;
            end
            if (rpend && !rvalid_i) begin
                if (r_wait == 0) begin
                    rvalid_i <= 1'b1;
                    rpend    <= 1'b0;
                    rdata_i  <= (raddr < 32'd256) ? mem[raddr[7:2]] : 32'h0;
                    rresp_i  <= (raddr < 32'd256) ? 2'b00 : 2'b10;
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
        end
    end

    // ==================================================
    // Reference model
    // ==================================================

    function automatic fetch_pkg::decoded_t ref_decode(logic [31:0] pc, logic [31:0] w,
                                                        logic err);
        fetch_pkg::decoded_t d;
        d.pc = pc;
        d.inst = w;
        d.err = err;
        d.rd = w[11:7];
        d.rs1 = w[19:15];
        d.rs2 = w[24:20];
        d.funct3 = w[14:12];
        d.funct7_b5 = w[30];
        d.imm = 32'h0;
        d.cls = fetch_pkg::ILLEGAL;
        case (w[6:0])
            7'b0110011: d.cls = fetch_pkg::ALU;
            7'b0010011: begin
                d.cls = fetch_pkg::ALU_IMM;
                d.imm = $signed(w[31:20]);
            end
            7'b0000011: begin
                d.cls = fetch_pkg::LOAD;
                d.imm = $signed(w[31:20]);
            end
            7'b1100111: begin
                d.cls = fetch_pkg::JUMP;
                d.imm = $signed(w[31:20]);
            end
            7'b0100011: begin
                d.cls = fetch_pkg::STORE;
                d.imm = $signed({w[31:25], w[11:7]});
            end
            7'b1100011: begin
                d.cls = fetch_pkg::BRANCH;
                d.imm = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
            end
            7'b1101111: begin
                d.cls = fetch_pkg::JUMP;
                d.imm = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
            end
            7'b0110111, 7'b0010111: begin
                d.cls = fetch_pkg::UPPER;
                d.imm = {w[31:12], 12'h0};
            end
            default: d.cls = fetch_pkg::ILLEGAL;
        endcase
        return d;
    endfunction

    // Walks the program from the reset PC and follows every JAL
    task automatic build_expected(input integer n);
        logic [31:0]         pc;
        logic                err;
        fetch_pkg::decoded_t d;
        exp_q.delete();
        pc = fetch_pkg::PC_START;
        for (int i = 0; i < n; i++) begin
            err = (pc >= 32'd256);
            d = ref_decode(pc, err ? 32'h0 : mem[pc[7:2]], err);
            exp_q.push_back(d);
            pc = (d.inst[6:0] == 7'b1101111 && !err) ? pc + d.imm : pc + 32'd4;
        end
    endtask

    function automatic logic [31:0] enc_jal(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // ==================================================
    // Checker
    // ==================================================

    task automatic check_field(string name, logic [31:0] e, logic [31:0] g);
        checks++;
        if (e !== g) begin
            errs++;
            $display("ERR %s expected %h got %h", name, e, g);
        end
    endtask

    always @(posedge clk) begin
        if (checking && rst_n_i) begin
            // Instruction fetches are unprivileged, secure, instruction accesses
            if (arvalid_o && arready_i) check_field("arprot_o", 3'b100, arprot_o);
            if (hold_pending) begin
                check_field("out_valid_o", 1, out_valid_o);
                checks++;
                if (out_o !== held) begin
                    errs++;
                    $display("ERR out_o expected %h got %h", held, out_o);
                end
            end
            if (out_valid_o && out_ready_i) begin
                check_field("pc", exp_q[got].pc, out_o.pc);
                check_field("cls", exp_q[got].cls, out_o.cls);
                check_field("rd", exp_q[got].rd, out_o.rd);
                check_field("rs1", exp_q[got].rs1, out_o.rs1);
                check_field("rs2", exp_q[got].rs2, out_o.rs2);
                check_field("funct3", exp_q[got].funct3, out_o.funct3);
                check_field("funct7_b5", exp_q[got].funct7_b5, out_o.funct7_b5);
                check_field("imm", exp_q[got].imm, out_o.imm);
                check_field("inst", exp_q[got].inst, out_o.inst);
                check_field("err", exp_q[got].err, out_o.err);
                got++;
            end
            hold_pending = out_valid_o && !out_ready_i;
            held = out_o;
        end
    end

    // ==================================================
    // Test sequencing
    // ==================================================

    task automatic load_program(input integer prog);
        for (int i = 0; i < 64; i++) mem[i] = fetch_pkg::INST_NOP ^ (i << 20);
        if (prog == 1) begin
            mem[0] = 32'h002081b3;
            mem[1] = 32'hfff30293;
            mem[2] = 32'h00812383;
            mem[3] = 32'hfe712e23;
            mem[4] = 32'hfe208ce3;
            mem[5] = 32'h12345537;
            mem[6] = 32'h00001597;
            mem[7] = 32'hffffffff;
        end else if (prog == 2) begin
            mem[0] = 32'h00100093;
            mem[1] = enc_jal(5'd1, 21'h1c);
            mem[2] = 32'h00420213;
            mem[3] = 32'habcde337;
            mem[8] = 32'h403100b3;
            mem[9] = enc_jal(5'd0, -21'sd28);
        end else begin
            mem[0] = enc_jal(5'd0, 21'h400);
        end
    endtask

    task automatic run_test(input integer num, input string name, input integer prog,
                            input integer n, input logic rnd);
        integer errs_before;
        errs_before = errs;
        @(posedge clk);
        rst_n_i <= 1'b0;
        checking = 1'b0;
        rand_ready <= rnd;
        load_program(prog);
        build_expected(n);
        got = 0;
        hold_pending = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_field("arvalid_o", 0, arvalid_o);
        check_field("rready_o", 0, rready_o);
        check_field("out_valid_o", 0, out_valid_o);
        @(posedge clk);
        rst_n_i <= 1'b1;
        checking <= 1'b1;
        cycles = 0;
        while (got < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > 40 * n + 200) begin
                $display("Timeout in test %0d after %0d cycles with %0d of %0d outputs",
                         num, cycles, got, n);
                $display("Checks failed");
                $finish;
            end
        end
        checking = 1'b0;
        $display("Test %0d %s: %s (%0d outputs)", num, name,
                 (errs == errs_before) ? "PASS" : "FAIL", got);
    endtask

    initial begin
        rst_n_i = 1'b0;
        arready_i = 1'b0;
        rvalid_i = 1'b0;
        rdata_i = 32'h0;
        rresp_i = 2'b00;
        out_ready_i = 1'b0;
        run_test(1, "straight-line classes", 1, 8, 1'b0);
        run_test(2, "forward and backward jal", 2, 6, 1'b0);
        run_test(3, "random back-pressure", 1, 8, 1'b1);
        run_test(4, "reset state and first pc", 1, 1, 1'b0);
        run_test(5, "fetch beyond memory", 3, 3, 1'b0);
        run_test(6, "jal under back-pressure", 2, 6, 1'b1);
        $display("Checks run %0d, errors %0d", checks, errs);
        if (errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- fetch_front_properties.sv
`timescale 1ns/10ps

module fetch_front_properties (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       arvalid_i,
    input  logic                       arready_i,
    input  logic [fetch_pkg::XLEN-1:0] araddr_i,
    input  logic                       rvalid_i,
    input  logic                       rready_i,
    input  fetch_pkg::decoded_t        out_i,
    input  logic                       out_valid_i,
    input  logic                       out_ready_i,
    input  logic                       redirect_i
);

    logic outstanding_q;

    // Set by the AR handshake and cleared by the R handshake
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            outstanding_q <= 1'b0;
        end else if (arvalid_i && arready_i) begin
            outstanding_q <= 1'b1;
        end else if (rvalid_i && rready_i) begin
            outstanding_q <= 1'b0;
        end
    end

    ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
        else $error("araddr changed while the read address was pending");

    r_outstanding: assert property (@(posedge clk) disable iff (!rst_n_i)
        rready_i |-> outstanding_q)
        else $error("rready high with no read outstanding");

    out_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_i))
        else $error("output packet changed under back-pressure");

    // Only the JAL itself may still sit at the output two cycles on
    redirect_gap: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_i |-> ##2 (!out_valid_i || $stable(out_i)))
        else $error("new output appeared too soon after a redirect");

endmodule

//--- fetch_front_top.sv
`timescale 1ns/10ps

module fetch_front_top #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = fetch_pkg::PC_START
) (
    input  logic                       clk,
    input  logic                       rst_n_i,

    output logic                       arvalid_o,
    input  logic                       arready_i,
    output logic [fetch_pkg::XLEN-1:0] araddr_o,
    output logic [2:0]                 arprot_o,

    input  logic                       rvalid_i,
    output logic                       rready_o,
    input  logic [fetch_pkg::XLEN-1:0] rdata_i,
    input  logic [1:0]                 rresp_i,

    output fetch_pkg::decoded_t        out_o,
    output logic                       out_valid_o,
    input  logic                       out_ready_i
);

    localparam fetch_pkg::fetch_pkt_t IF_BUBBLE = '{
        pc:   '0,
        inst: fetch_pkg::INST_NOP,
        err:  1'b0
    };

    // The NOP word as decode would see it
    localparam fetch_pkg::decoded_t ID_BUBBLE = '{
        pc:        '0,
        cls:       fetch_pkg::ALU_IMM,
        rd:        5'd0,
        rs1:       5'd0,
        rs2:       5'd0,
        funct3:    3'd0,
        funct7_b5: 1'b0,
        imm:       '0,
        inst:      fetch_pkg::INST_NOP,
        err:       1'b0
    };

    fetch_pkg::fetch_pkt_t      if_pkt;
    logic                       if_pkt_valid;
    fetch_pkg::fetch_pkt_t      id_pkt;
    logic                       id_pkt_valid;
    fetch_pkg::decoded_t        dec;
    logic                       dec_valid;
    logic                       redirect;
    logic [fetch_pkg::XLEN-1:0] redirect_pc;
    logic                       stall;

    // Back-pressure from the consumer holds the whole front end
    assign stall = out_valid_o & ~out_ready_i;

    inst_fetch #(
        .RESET_PC (RESET_PC)
    ) u_inst_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .arvalid_o     (arvalid_o),
        .arready_i     (arready_i),
        .araddr_o      (araddr_o),
        .arprot_o      (arprot_o),
        .rvalid_i      (rvalid_i),
        .rready_o      (rready_o),
        .rdata_i       (rdata_i),
        .rresp_i       (rresp_i),
        .stall_i       (stall),
        .pkt_o         (if_pkt),
        .pkt_valid_o   (if_pkt_valid)
    );

    stage_reg #(
        .payload_t (fetch_pkg::fetch_pkt_t),
        .BUBBLE    (IF_BUBBLE)
    ) u_if_id (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (if_pkt_valid),
        .stall_i (stall),
        .flush_i (redirect),
        .data_i  (if_pkt),
        .data_o  (id_pkt),
        .valid_o (id_pkt_valid)
    );

    inst_decode u_inst_decode (
        .pkt_i         (id_pkt),
        .pkt_valid_i   (id_pkt_valid),
        .stall_i       (stall),
        .dec_o         (dec),
        .dec_valid_o   (dec_valid),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    stage_reg #(
        .payload_t (fetch_pkg::decoded_t),
        .BUBBLE    (ID_BUBBLE)
    ) u_id_ex (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .valid_i (dec_valid),
        .stall_i (stall),
        .flush_i (1'b0),
        .data_i  (dec),
        .data_o  (out_o),
        .valid_o (out_valid_o)
    );

endmodule

//--- inst_decode.sv
`timescale 1ns/10ps

module inst_decode (
    input  fetch_pkg::fetch_pkt_t      pkt_i,
    input  logic                       pkt_valid_i,
    input  logic                       stall_i,

    output fetch_pkg::decoded_t        dec_o,
    output logic                       dec_valid_o,

    output logic                       redirect_o,
    output logic [fetch_pkg::XLEN-1:0] redirect_pc_o
);

    logic [31:0]                inst;
    logic [6:0]                 opcode;
    logic [fetch_pkg::XLEN-1:0] imm_i;
    logic [fetch_pkg::XLEN-1:0] imm_s;
    logic [fetch_pkg::XLEN-1:0] imm_b;
    logic [fetch_pkg::XLEN-1:0] imm_u;
    logic [fetch_pkg::XLEN-1:0] imm_j;
    logic                       is_jal;

    assign inst   = pkt_i.inst;
    assign opcode = inst[6:0];

    // ==================================================
    // Immediate formats
    // ==================================================

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // ==================================================
    // Field split and classification
    // ==================================================

    always_comb begin
        dec_o.pc        = pkt_i.pc;
        dec_o.rd        = inst[11:7];
        dec_o.rs1       = inst[19:15];
        dec_o.rs2       = inst[24:20];
        dec_o.funct3    = inst[14:12];
        dec_o.funct7_b5 = inst[30];
        dec_o.inst      = inst;
        dec_o.err       = pkt_i.err;
        dec_o.cls       = fetch_pkg::ILLEGAL;
        dec_o.imm       = '0;

        case (opcode)
            fetch_pkg::OPC_LUI, fetch_pkg::OPC_AUIPC: begin
                dec_o.cls = fetch_pkg::UPPER;
                dec_o.imm = imm_u;
            end
            fetch_pkg::OPC_JAL: begin
                dec_o.cls = fetch_pkg::JUMP;
                dec_o.imm = imm_j;
            end
            // JALR is classified here but resolved further down the pipe
            fetch_pkg::OPC_JALR: begin
                dec_o.cls = fetch_pkg::JUMP;
                dec_o.imm = imm_i;
            end
            fetch_pkg::OPC_BRANCH: begin
                dec_o.cls = fetch_pkg::BRANCH;
                dec_o.imm = imm_b;
            end
            fetch_pkg::OPC_LOAD: begin
                dec_o.cls = fetch_pkg::LOAD;
                dec_o.imm = imm_i;
            end
            fetch_pkg::OPC_STORE: begin
                dec_o.cls = fetch_pkg::STORE;
                dec_o.imm = imm_s;
            end
            fetch_pkg::OPC_OPIMM: begin
                dec_o.cls = fetch_pkg::ALU_IMM;
                dec_o.imm = imm_i;
            end
            fetch_pkg::OPC_OP: begin
                dec_o.cls = fetch_pkg::ALU;
            end
            default: begin
                dec_o.cls = fetch_pkg::ILLEGAL;
            end
        endcase
    end

    assign dec_valid_o = pkt_valid_i;

    // ==================================================
    // JAL resolved in decode
    // ==================================================

    // A word that came back with a bus error is never followed
    assign is_jal        = (opcode == fetch_pkg::OPC_JAL) & ~pkt_i.err;
    assign redirect_o    = pkt_valid_i & ~stall_i & is_jal;
    assign redirect_pc_o = pkt_i.pc + imm_j;

endmodule

//--- stage_reg.sv
`timescale 1ns/10ps

module stage_reg #(
    parameter type      payload_t = logic [31:0],
    parameter payload_t BUBBLE    = '0
) (
    input  logic     clk,
    input  logic     rst_n_i,

    input  logic     valid_i,
    input  logic     stall_i,
    input  logic     flush_i,

    input  payload_t data_i,

    output payload_t data_o,
    output logic     valid_o
);

    payload_t data_q;
    logic     valid_q;

    assign data_o  = data_q;
    assign valid_o = valid_q;

    // ==================================================
    // Valid bit
    // ==================================================

    // Flush beats stall, stall beats load, an empty cycle leaves a bubble
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (stall_i) begin
            valid_q <= valid_q;
        end else begin
            valid_q <= valid_i;
        end
    end

    // ==================================================
    // Payload
    // ==================================================

    // Data keeps its last value across empty cycles
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            data_q <= BUBBLE;
        end else if (stall_i) begin
            data_q <= data_q;
        end else if (valid_i) begin
            data_q <= data_i;
        end else begin
            data_q <= data_q;
        end
    end

endmodule

//--- inst_fetch.sv
`timescale 1ns/10ps

module inst_fetch #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = fetch_pkg::PC_START
) (
    input  logic                       clk,
    input  logic                       rst_n_i,

    input  logic                       redirect_i,
    input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,

    output logic                       arvalid_o,
    input  logic                       arready_i,
    output logic [fetch_pkg::XLEN-1:0] araddr_o,
    output logic [2:0]                 arprot_o,

    input  logic                       rvalid_i,
    output logic                       rready_o,
    input  logic [fetch_pkg::XLEN-1:0] rdata_i,
    input  logic [1:0]                 rresp_i,

    input  logic                       stall_i,
    output fetch_pkg::fetch_pkt_t      pkt_o,
    output logic                       pkt_valid_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA
    } rd_state_e;

    rd_state_e                  state_q;
    rd_state_e                  state_d;
    logic [fetch_pkg::XLEN-1:0] pc_q;
    logic [fetch_pkg::XLEN-1:0] pc_d;
    logic [fetch_pkg::XLEN-1:0] araddr_q;
    logic                       drop_q;
    logic                       drop_d;
    logic                       ar_hs;
    logic                       r_hs;
    logic                       issue;

    assign ar_hs = arvalid_o & arready_i;
    assign r_hs  = rvalid_i & rready_o;

    // A new read goes out after reset and right after every completed read
    assign issue = (state_q == S_IDLE) | r_hs;

    assign arvalid_o = (state_q == S_ADDR);
    assign araddr_o  = araddr_q;
    // Unprivileged, secure, instruction access
    assign arprot_o  = 3'b100;

    // A stale response is taken even under stall since it never reaches IF/ID
    assign rready_o = (state_q == S_DATA) & (drop_q | ~stall_i);

    assign pkt_o       = '{pc: araddr_q, inst: rdata_i, err: (rresp_i != 2'b00)};
    assign pkt_valid_o = r_hs & ~drop_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: state_d = S_ADDR;
            S_ADDR: if (ar_hs) state_d = S_DATA;
            S_DATA: if (r_hs) state_d = S_ADDR;
            default: state_d = S_IDLE;
        endcase
    end

    // Redirect wins over the sequential increment
    always_comb begin
        if (redirect_i) begin
            pc_d = redirect_pc_i;
        end else if (r_hs && !drop_q) begin
            pc_d = pc_q + 32'd4;
        end else begin
            pc_d = pc_q;
        end
    end

    // The read already on the bus belongs to the old path and must be swallowed
    always_comb begin
        if (redirect_i && (state_q == S_ADDR || (state_q == S_DATA && !r_hs))) begin
            drop_d = 1'b1;
        end else if (r_hs) begin
            drop_d = 1'b0;
        end else begin
            drop_d = drop_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            pc_q    <= RESET_PC;
            drop_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
            drop_q  <= drop_d;
        end
    end

    // Latched at issue so the address holds while the slave keeps arready low
    always_ff @(posedge clk) begin
        if (issue) begin
            araddr_q <= pc_d;
        end
    end

endmodule

//--- fetch_pkg.sv
package fetch_pkg;

    // ==================================================
    // Widths and fixed words
    // ==================================================

    parameter int XLEN = 32;

    parameter logic [XLEN-1:0] PC_START = 32'h0000_0000;

    // addi x0, x0, 0
    parameter logic [31:0] INST_NOP = 32'h0000_0013;

    // ==================================================
    // RV32I base opcodes
    // ==================================================

    parameter logic [6:0] OPC_LUI    = 7'b0110111;
    parameter logic [6:0] OPC_AUIPC  = 7'b0010111;
    parameter logic [6:0] OPC_JAL    = 7'b1101111;
    parameter logic [6:0] OPC_JALR   = 7'b1100111;
    parameter logic [6:0] OPC_BRANCH = 7'b1100011;
    parameter logic [6:0] OPC_LOAD   = 7'b0000011;
    parameter logic [6:0] OPC_STORE  = 7'b0100011;
    parameter logic [6:0] OPC_OPIMM  = 7'b0010011;
    parameter logic [6:0] OPC_OP     = 7'b0110011;

    typedef enum logic [2:0] {
        ALU,
        ALU_IMM,
        LOAD,
        STORE,
        BRANCH,
        JUMP,
        UPPER,
        ILLEGAL
    } inst_class_e;

    // ==================================================
    // Pipeline packets
    // ==================================================

    // One fetched word as it leaves the read data channel
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
        logic            err;
    } fetch_pkt_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_class_e     cls;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [2:0]      funct3;
        logic            funct7_b5;
        logic [XLEN-1:0] imm;
        logic [31:0]     inst;
        logic            err;
    } decoded_t;

endpackage
